/* ExecuteCore.f */
src/aluPkg.sv
src/isaPkg.sv
src/aluIf.sv
src/Alu.sv
src/AluControl.sv
src/RegisterFile.sv
src/ExecuteCore.sv
verification/ClockGen.sv
verification/ResultChecker.sv
verification/tbExecuteCore.sv

/* Makefile */
SIM := obj_dir/simExecuteCore

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		--top-module tbExecuteCore -f ExecuteCore.f -o simExecuteCore
	@out="$$(./$(SIM))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'Simulation finished: PASS'

clean:
	rm -rf obj_dir

/* verification/execVectors.txt */
# valid instr legal writeReg result, all hex
# one line per cycle after reset
0 00000000 0 00 00000000
0 00000000 0 00 00000000
# immediate loads from r0, then andi and slti on them
1 20010005 1 01 00000005
1 2002FFFD 1 02 FFFFFFFD
1 34038001 1 03 00008001
1 20048000 1 04 FFFF8000
1 380500FF 1 05 000000FF
1 3066FFFF 1 06 00008001
1 28470000 1 07 00000001
# register-register ops
1 00224020 1 08 00000002
1 00214822 1 09 00000000
1 00655024 1 0A 00000001
1 00655825 1 0B 000080FF
1 00656026 1 0C 000080FE
1 00256827 1 0D FFFFFF00
1 0041702A 1 0E 00000001
1 0022782A 1 0F 00000000
1 0082802A 1 10 00000001
1 00418822 1 11 FFFFFFF8
# dependent chain on r18 and r19
1 20120007 1 12 00000007
1 02529020 1 12 0000000E
1 2252FFFF 1 12 0000000D
1 02419822 1 13 00000008
1 02729826 1 13 00000005
# r0 as destination, then reads of r0
1 20200010 1 00 00000015
1 0001A020 1 14 00000005
1 0000A025 1 14 00000000
# bad funct, bad opcode, unstrobed addi to r9
1 0021483F 0 00 00000000
1 FC2A0001 0 00 00000000
0 2009FFFF 1 00 00000000
# r9 and r10 untouched by the rejected words
1 012AA820 1 15 00000001
0 00000000 0 00 00000000

/* verification/tbExecuteCore.sv */
`timescale 1ns/1ps

module tbExecuteCore import aluPkg::*, isaPkg::*; ();
    localparam string vectorFile  = "verification/execVectors.txt";
    localparam int    slackCycles = 20;

    logic                 clk;
    logic                 rstN;
    logic                 instrValid;
    logic [dataWidth-1:0] instr;
    logic                 resultValid;
    logic [dataWidth-1:0] result;
    regAddrT              writeReg;
    logic                 zero;

    // expectation for the instruction now at the outputs
    logic                 expValid;
    logic [dataWidth-1:0] expResult;
    regAddrT              expReg;

    // one entry per vector line
    logic                 vecValid[$];
    logic [dataWidth-1:0] vecInstr[$];
    logic                 vecLegal[$];
    regAddrT              vecReg[$];
    logic [dataWidth-1:0] vecResult[$];

    int   loadErrors = 0;
    int   cycleCount = 0;
    int   cycleLimit = slackCycles;
    logic runDone    = 1'b0;
    int   valueErrors;
    int   protocolErrors;
    int   checksDone;

    ClockGen clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    ExecuteCore DUT (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .result      (result),
        .writeReg    (writeReg),
        .zero        (zero)
    );

    ResultChecker resultCheck (
        .clk                (clk),
        .rstN               (rstN),
        .resultValid        (resultValid),
        .result             (result),
        .writeReg           (writeReg),
        .zero               (zero),
        .expValid           (expValid),
        .expResult          (expResult),
        .expReg             (expReg),
        .valueErrorCount    (valueErrors),
        .protocolErrorCount (protocolErrors),
        .checkCount         (checksDone)
    );

    // columns: valid, instruction word, legal, writeReg, result; # starts a comment
    task automatic loadVectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] res;
        fd = $fopen(vectorFile, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", vectorFile);
            loadErrors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h", v, w, l, r, res);
                if (fields == 5) begin
                    vecValid.push_back(v[0]);
                    vecInstr.push_back(w);
                    vecLegal.push_back(l[0]);
                    vecReg.push_back(regAddrT'(r));
                    vecResult.push_back(res);
                end else if (fields > 0) begin
                    $display("malformed vector line: %s", line);
                    loadErrors++;
                end
            end
        end
        $fclose(fd);
    endtask

    // an instruction shows up at the outputs one cycle after it is driven
    task automatic setExpected(input int idx);
        expValid  <= vecValid[idx] && vecLegal[idx];
        expResult <= vecResult[idx];
        expReg    <= vecReg[idx];
    endtask

    task automatic runVectors();
        int n;
        n = vecInstr.size();
        while (!rstN) @(posedge clk);
        for (int i = 0; i < n; i++) begin
            instrValid <= vecValid[i];
            instr      <= vecInstr[i];
            if (i > 0) begin
                setExpected(i - 1);
            end
            @(posedge clk);
        end
        instrValid <= 1'b0;
        instr      <= '0;
        setExpected(n - 1);
        @(posedge clk);
        expValid <= 1'b0;
        // one idle output cycle, then let its check land
        @(posedge clk);
        @(posedge clk);
    endtask

    // run limit from the vector count
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!runDone && cycleCount >= cycleLimit) begin
            $display("timeout: run still busy after %0d cycles", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        instrValid = 1'b0;
        instr      = '0;
        expValid   = 1'b0;
        expResult  = '0;
        expReg     = '0;
        loadVectors();
        cycleLimit = vecInstr.size() + slackCycles;
        if (loadErrors != 0 || vecInstr.size() == 0) begin
            $display("no usable vectors, run stopped before reset release");
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            runVectors();
            runDone = 1'b1;
            $display("errors: %0d value, %0d protocol, %0d load, over %0d checks",
                     valueErrors, protocolErrors, loadErrors, checksDone);
            if (valueErrors == 0 && protocolErrors == 0 && checksDone > 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

/* verification/ResultChecker.sv */
`timescale 1ns/1ps

module ResultChecker import aluPkg::*, isaPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    // dut outputs
    input  logic                 resultValid,
    input  logic [dataWidth-1:0] result,
    input  regAddrT              writeReg,
    input  logic                 zero,
    // expected values, already aligned to the output cycle
    input  logic                 expValid,
    input  logic [dataWidth-1:0] expResult,
    input  regAddrT              expReg,
    // running totals for the closing line
    output int                   valueErrorCount,
    output int                   protocolErrorCount,
    output int                   checkCount
);
    int   valueErrors    = 0;
    int   protocolErrors = 0;
    int   checks         = 0;
    // set once the first accepted instruction reaches the output
    logic seenResult     = 1'b0;

    assign valueErrorCount    = valueErrors;
    assign protocolErrorCount = protocolErrors;
    assign checkCount         = checks;

    task automatic compareWord(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
            valueErrors++;
        end
    endtask

    // falling edge, outputs settled half a period after the update
    always @(negedge clk) begin
        if (rstN === 1'b1) begin
            checks++;
            if (expValid) begin
                seenResult = 1'b1;
                if (resultValid !== 1'b1) begin
                    $display("t=%0t: resultValid stayed low after an accepted instruction",
                             $time);
                    protocolErrors++;
                end else begin
                    compareWord("result", expResult, result);
                    compareWord("writeReg", 32'(expReg), 32'(writeReg));
                    // zero flag follows an all-zero result
                    compareWord("zero", 32'(expResult == '0), 32'(zero));
                end
            end else begin
                if (resultValid !== 1'b0) begin
                    $display("t=%0t: resultValid rose with no accepted instruction", $time);
                    protocolErrors++;
                end
                // reset value still showing before the first result
                if (!seenResult) begin
                    compareWord("result", '0, result);
                end
            end
        end
    end

endmodule

/* verification/ClockGen.sv */
`timescale 1ns/1ps

module ClockGen (
    output logic clk,
    output logic rstN
);
    // 40 ns period
    localparam int halfPeriod  = 20;
    localparam int resetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // reset low for the first rising edges, released on an edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

/* src/ExecuteCore.sv */
`timescale 1ns/1ps

module ExecuteCore import aluPkg::*, isaPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic [dataWidth-1:0] instr,
    output logic                 resultValid,
    output logic [dataWidth-1:0] result,
    output regAddrT              writeReg,
    output logic                 zero
);
    instrT                decoded;
    aluOpT                aluOp;
    logic                 useImm;
    logic                 signExtImm;
    regAddrT              destReg;
    logic                 legal;
    logic                 accept;
    logic                 writeEn;
    logic [dataWidth-1:0] readDataA;
    logic [dataWidth-1:0] readDataB;
    logic [dataWidth-1:0] immExt;

    aluIf aluBus (.clk(clk));

    assign decoded = instrT'(instr);

    AluControl decoder (
        .instr      (decoded),
        .aluOp      (aluOp),
        .useImm     (useImm),
        .signExtImm (signExtImm),
        .destReg    (destReg),
        .legal      (legal)
    );

    // only legal words are taken
    assign accept  = instrValid && legal;
    // r0 writes still show at the output but skip the file
    assign writeEn = accept && (destReg != '0);

    RegisterFile regFile (
        .clk       (clk),
        .rstN      (rstN),
        .readAddrA (decoded.rType.rs),
        .readAddrB (decoded.rType.rt),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (writeEn),
        .writeAddr (destReg),
        .writeData (aluBus.y)
    );

    // immediate extension as the decoder asks
    assign immExt = signExtImm
        ? {{(dataWidth-immWidth){decoded.iType.imm[immWidth-1]}}, decoded.iType.imm}
        : {{(dataWidth-immWidth){1'b0}}, decoded.iType.imm};

    // operand mux into the alu
    assign aluBus.op = aluOp;
    assign aluBus.a  = readDataA;
    assign aluBus.b  = useImm ? immExt : readDataB;

    Alu alu (
        .bus (aluBus)
    );

    // output stage, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultValid <= 1'b0;
            result      <= '0;
            writeReg    <= '0;
            zero        <= 1'b0;
        end else begin
            resultValid <= accept;
            // hold last result while idle
            if (accept) begin
                result   <= aluBus.y;
                writeReg <= destReg;
                zero     <= aluBus.zero;
            end
        end
    end

    // a valid result always traces back to a legal strobe
    assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> $past(instrValid && legal));

endmodule

/* src/RegisterFile.sv */
`timescale 1ns/1ps

module RegisterFile import aluPkg::*, isaPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  regAddrT              readAddrA,
    input  regAddrT              readAddrB,
    output logic [dataWidth-1:0] readDataA,
    output logic [dataWidth-1:0] readDataB,
    input  logic                 writeEn,
    input  regAddrT              writeAddr,
    input  logic [dataWidth-1:0] writeData
);
    logic [dataWidth-1:0] regs [numRegs];

    // write port, entry 0 never changes
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // combinational reads
    // register 0 is hardwired to zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    // a write of any address never disturbs register 0
    assert property (@(posedge clk) disable iff (!rstN)
        writeEn |=> (regs[0] == '0));

endmodule

/* src/AluControl.sv */
`timescale 1ns/1ps

module AluControl import aluPkg::*, isaPkg::*; (
    input  instrT   instr,
    output aluOpT   aluOp,
    output logic    useImm,
    output logic    signExtImm,
    output regAddrT destReg,
    output logic    legal
);

    always_comb begin
        // safe defaults for an unknown word
        aluOp      = aluAdd;
        useImm     = 1'b0;
        signExtImm = 1'b0;
        destReg    = instr.rType.rd;
        legal      = 1'b0;

        case (instr.rType.opcode)
            opR: begin
                // register-register forms, target is rd
                destReg = instr.rType.rd;
                // shamt must stay clear on these ops
                legal   = (instr.rType.shamt == 5'd0);
                case (instr.rType.funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr:  aluOp = aluOr;
                    fnXor: aluOp = aluXor;
                    fnNor: aluOp = aluNor;
                    fnSlt: aluOp = aluSlt;
                    default: begin
                        // unknown funct
                        legal = 1'b0;
                    end
                endcase
            end
            // arithmetic immediates sign-extend
            opAddi: begin
                aluOp      = aluAdd;
                useImm     = 1'b1;
                signExtImm = 1'b1;
                destReg    = instr.iType.rt;
                legal      = 1'b1;
            end
            opSlti: begin
                aluOp      = aluSlt;
                useImm     = 1'b1;
                signExtImm = 1'b1;
                destReg    = instr.iType.rt;
                legal      = 1'b1;
            end
            // logic immediates zero-extend
            opAndi: begin
                aluOp   = aluAnd;
                useImm  = 1'b1;
                destReg = instr.iType.rt;
                legal   = 1'b1;
            end
            opOri: begin
                aluOp   = aluOr;
                useImm  = 1'b1;
                destReg = instr.iType.rt;
                legal   = 1'b1;
            end
            opXori: begin
                aluOp   = aluXor;
                useImm  = 1'b1;
                destReg = instr.iType.rt;
                legal   = 1'b1;
            end
            default: begin
                // unknown opcode leaves legal low
                legal = 1'b0;
            end
        endcase
    end

endmodule

/* src/Alu.sv */
`timescale 1ns/1ps

// add/sub half of the alu
module AluArith import aluPkg::*; (
    input  logic                 sub,
    input  logic                 slt,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] y
);
    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic                 less;

    assign sum  = a + b;
    assign diff = a - b;
    // two's complement compare, not the sign of diff
    assign less = $signed(a) < $signed(b);

    always_comb begin
        if (slt) begin
            // slt yields 0 or 1
            y = {{(dataWidth-1){1'b0}}, less};
        end else begin
            y = sub ? diff : sum;
        end
    end
endmodule

// logic half of the alu
module AluLogic import aluPkg::*; (
    input  logic [1:0]           sel,
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    output logic [dataWidth-1:0] y
);
    logic [dataWidth-1:0] andOr;
    logic [dataWidth-1:0] xorNor;

    // first level picks within each pair
    assign andOr  = sel[0] ? (a | b) : (a & b);
    assign xorNor = sel[0] ? ~(a | b) : (a ^ b);

    // second level picks the pair
    assign y = sel[1] ? xorNor : andOr;
endmodule

module Alu import aluPkg::*; (
    aluIf.alu bus
);
    logic [3:0]           opBits;
    logic [dataWidth-1:0] arithY;
    logic [dataWidth-1:0] logicY;

    assign opBits = bus.op;

    AluArith arithUnit (
        .sub (opBits[opSubBit]),
        .slt (opBits[opSltBit]),
        .a   (bus.a),
        .b   (bus.b),
        .y   (arithY)
    );

    AluLogic logicUnit (
        .sel (opBits[1:0]),
        .a   (bus.a),
        .b   (bus.b),
        .y   (logicY)
    );

    // unit select
    assign bus.y    = opBits[opLogicBit] ? logicY : arithY;
    assign bus.zero = ~|bus.y;

    // subtract result is zero exactly when the operands match
    assert property (@(posedge bus.clk)
        (bus.op == aluSub) |-> (bus.zero == (bus.a == bus.b)));

    // slt gives zero whenever a is not below b
    // signed order equals unsigned order with the sign bits flipped
    assert property (@(posedge bus.clk)
        (bus.op == aluSlt) |-> (bus.zero ==
            !({~bus.a[dataWidth-1], bus.a[dataWidth-2:0]} <
              {~bus.b[dataWidth-1], bus.b[dataWidth-2:0]})));

endmodule

/* src/aluIf.sv */
`timescale 1ns/1ps

interface aluIf import aluPkg::*; (
    input logic clk
);
    // operation and operands from the execute core
    aluOpT                op;
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;

    // combinational result back from the alu
    logic [dataWidth-1:0] y;
    logic                 zero;

    // execute core side
    modport core (
        output op, a, b,
        input  y, zero
    );

    // alu side, clk only feeds the checks
    modport alu (
        input  clk, op, a, b,
        output y, zero
    );

endinterface

/* src/isaPkg.sv */
package isaPkg;

    // register file geometry
    localparam int numRegs   = 32;
    localparam int immWidth  = 16;

    // 5-bit register index
    typedef logic [4:0] regAddrT;

    // one instruction word seen as either format
    // field order follows the mips encoding, msb first
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            regAddrT    rs;
            regAddrT    rt;
            regAddrT    rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]          opcode;
            regAddrT             rs;
            regAddrT             rt;
            logic [immWidth-1:0] imm;
        } iType;
    } instrT;

    // primary opcodes
    localparam logic [5:0] opR    = 6'b000000;
    localparam logic [5:0] opAddi = 6'b001000;
    localparam logic [5:0] opSlti = 6'b001010;
    localparam logic [5:0] opAndi = 6'b001100;
    localparam logic [5:0] opOri  = 6'b001101;
    localparam logic [5:0] opXori = 6'b001110;

    // funct field of r-type words
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnNor  = 6'b100111;
    localparam logic [5:0] fnSlt  = 6'b101010;

endpackage

/* src/aluPkg.sv */
package aluPkg;

    // operand and result width
    localparam int dataWidth = 32;

    // alu operation codes
    // bit 2 picks the logic unit over the arithmetic unit
    // bits 1:0 pick the function inside the chosen unit
    // bit 3 marks the set-less-than variant of subtract
    typedef enum logic [3:0] {
        // arithmetic unit
        aluAdd = 4'b0000,
        aluSub = 4'b0010,
        // logic unit, first pair
        aluAnd = 4'b0100,
        aluOr  = 4'b0101,
        // logic unit, second pair
        aluXor = 4'b0110,
        aluNor = 4'b0111,
        // signed compare through the subtract path
        aluSlt = 4'b1010
    } aluOpT;

    // bit positions inside the operation code
    localparam int opSubBit   = 1;
    localparam int opLogicBit = 2;
    localparam int opSltBit   = 3;

endpackage
